// File: exu_pkg.sv
package exu_pkg;

  localparam int XLEN = 64;

  // Major opcodes.
  localparam logic [6:0] OP_ALU_R  = 7'b0110011;
  localparam logic [6:0] OP_ALU_I  = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // System func3, carried in imm[3:0].
  localparam logic [3:0] F3_PRIV   = 4'h0;
  localparam logic [3:0] F3_CSRRW  = 4'h1;
  localparam logic [3:0] F3_CSRRS  = 4'h2;
  localparam logic [3:0] F3_CSRRC  = 4'h3;
  localparam logic [3:0] F3_CSRRWI = 4'h5;
  localparam logic [3:0] F3_CSRRSI = 4'h6;
  localparam logic [3:0] F3_CSRRCI = 4'h7;

  // Privileged funct12, carried in imm[15:4].
  localparam logic [11:0] FN_ECALL  = 12'h000;
  localparam logic [11:0] FN_EBREAK = 12'h001;
  localparam logic [11:0] FN_MRET   = 12'h302;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_AND  = 4'd2;
  localparam logic [3:0] ALU_OR   = 4'd3;
  localparam logic [3:0] ALU_XOR  = 4'd4;
  localparam logic [3:0] ALU_SLL  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_SLT  = 4'd8;
  localparam logic [3:0] ALU_SLTU = 4'd9;
  localparam logic [3:0] ALU_SLE  = 4'd10;
  localparam logic [3:0] ALU_SLEU = 4'd11;

  localparam logic [XLEN-1:0] ECALL_CAUSE = 64'd11; // Environment call from M-mode.

  // Data memory geometry and response latency.
  localparam int MEM_DEPTH = 256;
  localparam int MEM_LAT   = 2;
  localparam int MEM_AW    = $clog2(MEM_DEPTH);
  localparam int MEM_CW    = $clog2(MEM_LAT + 1);

endpackage

// File: exu_alu.sv
`timescale 1ns/10ps

module exu_alu (
  input  logic [exu_pkg::XLEN-1:0] a_i,
  input  logic [exu_pkg::XLEN-1:0] b_i,
  input  logic [3:0]               op_i,
  output logic [exu_pkg::XLEN-1:0] res_o
);

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b_i[5:0]; // RV64 shift amount.
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;
  assign eq    = a_i == b_i;

  always_comb begin
    res_o = '0;
    case (op_i)
      exu_pkg::ALU_ADD:  res_o = a_i + b_i;
      exu_pkg::ALU_SUB:  res_o = a_i - b_i;
      exu_pkg::ALU_AND:  res_o = a_i & b_i;
      exu_pkg::ALU_OR:   res_o = a_i | b_i;
      exu_pkg::ALU_XOR:  res_o = a_i ^ b_i;
      exu_pkg::ALU_SLL:  res_o = a_i << shamt;
      exu_pkg::ALU_SRL:  res_o = a_i >> shamt;
      exu_pkg::ALU_SRA:  res_o = $signed(a_i) >>> shamt;
      // Compares give 0 or 1.
      exu_pkg::ALU_SLT:  res_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
      exu_pkg::ALU_SLTU: res_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
      exu_pkg::ALU_SLE:  res_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_s | eq};
      exu_pkg::ALU_SLEU: res_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_u | eq};
      default:           res_o = '0;
    endcase
  end

endmodule

// File: exu_csr_file.sv
`timescale 1ns/10ps

module exu_csr_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we_i,
  input  logic                     ecall_i,
  input  logic [11:0]              waddr_i,
  input  logic [11:0]              waddr2_i,
  input  logic [exu_pkg::XLEN-1:0] wdata_i,
  input  logic [exu_pkg::XLEN-1:0] wdata2_i,
  output logic [exu_pkg::XLEN-1:0] rdata_o,
  output logic [exu_pkg::XLEN-1:0] mepc_o,
  output logic [exu_pkg::XLEN-1:0] mtvec_o
);

  logic [exu_pkg::XLEN-1:0] mstatus;
  logic [exu_pkg::XLEN-1:0] mtvec;
  logic [exu_pkg::XLEN-1:0] mepc;
  logic [exu_pkg::XLEN-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (we_i) begin
        case (waddr_i)
          exu_pkg::CSR_MSTATUS: mstatus <= wdata_i;
          exu_pkg::CSR_MTVEC:   mtvec   <= wdata_i;
          exu_pkg::CSR_MEPC:    mepc    <= wdata_i;
          exu_pkg::CSR_MCAUSE:  mcause  <= wdata_i;
          default: ;
        endcase
      end
      // Second port, only used by ecall. Wins on a clash.
      if (ecall_i) begin
        case (waddr2_i)
          exu_pkg::CSR_MSTATUS: mstatus <= wdata2_i;
          exu_pkg::CSR_MTVEC:   mtvec   <= wdata2_i;
          exu_pkg::CSR_MEPC:    mepc    <= wdata2_i;
          exu_pkg::CSR_MCAUSE:  mcause  <= wdata2_i;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (waddr_i)
      exu_pkg::CSR_MSTATUS: rdata_o = mstatus;
      exu_pkg::CSR_MTVEC:   rdata_o = mtvec;
      exu_pkg::CSR_MEPC:    rdata_o = mepc;
      exu_pkg::CSR_MCAUSE:  rdata_o = mcause;
      default:              rdata_o = '0; // Unimplemented CSR.
    endcase
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

  // An ecall always writes mcause alongside mepc.
  a_ecall_with_we: assert property (@(posedge clk) disable iff (rst) ecall_i |-> we_i);

endmodule

// File: exu_data_mem.sv
`timescale 1ns/10ps

module exu_data_mem (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [exu_pkg::XLEN-1:0] addr_i,
  input  logic [exu_pkg::XLEN-1:0] wdata_i,
  output logic [exu_pkg::XLEN-1:0] rdata_o,
  output logic                     rvalid_o,
  output logic                     wready_o
);

  logic [exu_pkg::XLEN-1:0]   mem [0:exu_pkg::MEM_DEPTH-1];
  logic [exu_pkg::MEM_DEPTH-1:0] written; // Per-word written flag.
  logic [exu_pkg::MEM_AW-1:0] idx;
  logic [exu_pkg::MEM_CW-1:0] cnt;
  logic                       busy, done, fire;

  assign idx  = addr_i[exu_pkg::MEM_AW+2:3]; // Doubleword index.
  assign fire = busy && (cnt == exu_pkg::MEM_CW'(exu_pkg::MEM_LAT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      cnt      <= '0;
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
      written  <= '0;
    end else begin
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
      if (done) begin
        if (!req_i) done <= 1'b0; // Wait for the request to drop.
      end else if (fire) begin
        busy     <= 1'b0;
        done     <= 1'b1;
        rvalid_o <= !we_i;
        wready_o <= we_i;
        if (we_i) written[idx] <= 1'b1;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
      end else if (req_i) begin
        busy <= 1'b1;
        cnt  <= exu_pkg::MEM_CW'(1); // The cycle that sees the request is the first.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire && we_i) mem[idx] <= wdata_i;
    if (fire && !we_i) rdata_o <= written[idx] ? mem[idx] : '0;
  end

  a_strobe_needs_req: assert property (@(posedge clk) disable iff (rst)
    (rvalid_o || wready_o) |-> req_i);

endmodule

// File: exu_stage.sv
`timescale 1ns/10ps

module exu_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     prev_valid_i,
  input  logic                     next_ready_i,
  output logic                     ready_o,
  output logic                     valid_o,
  input  logic                     ren_i,
  input  logic                     wen_i,
  input  logic                     rwen_i,
  input  logic [4:0]               rd_i,
  input  logic [exu_pkg::XLEN-1:0] imm_i,
  input  logic [exu_pkg::XLEN-1:0] op1_i,
  input  logic [exu_pkg::XLEN-1:0] op2_i,
  input  logic [exu_pkg::XLEN-1:0] op_j_i,
  input  logic [3:0]               alu_op_i,
  input  logic [6:0]               opcode_i,
  input  logic [exu_pkg::XLEN-1:0] pc_i,
  output logic [exu_pkg::XLEN-1:0] reg_wdata_o,
  output logic [exu_pkg::XLEN-1:0] npc_wdata_o,
  output logic                     use_npc_o,
  output logic                     ebreak_o,
  output logic [4:0]               rd_o,
  output logic                     rwen_o,
  output logic                     mem_req_o,
  output logic [exu_pkg::XLEN-1:0] mem_addr_o,
  output logic [exu_pkg::XLEN-1:0] mem_wdata_o,
  output logic                     mem_we_o,
  input  logic [exu_pkg::XLEN-1:0] mem_rdata_i,
  input  logic                     mem_rvalid_i,
  input  logic                     mem_wready_i
);

  typedef enum logic [1:0] {S_IDLE, S_BUSY, S_WAIT} state_t;

  state_t                   state;
  logic [6:0]               opcode_q;
  logic [3:0]               alu_op_q;
  logic [exu_pkg::XLEN-1:0] imm_q, pc_q, src1_q, src2_q, addr_q, mem_rdata_q;
  logic                     ren_q, wen_q;
  logic [exu_pkg::XLEN-1:0] alu_res;
  logic [exu_pkg::XLEN-1:0] csr_rdata, csr_wdata, mepc, mtvec;
  logic [11:0]              csr_addr;
  logic                     csr_wen, commit, accept, mem_done;
  logic                     is_sys, is_priv, is_ecall, is_mret, is_ebreak;

  assign accept   = (state == S_IDLE) && prev_valid_i;
  assign commit   = valid_o && next_ready_i;
  assign mem_done = (ren_q && mem_rvalid_i) || (wen_q && mem_wready_i);
  assign ready_o  = (state == S_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      valid_o   <= 1'b0;
      mem_req_o <= 1'b0;
      rwen_o    <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (accept) begin
          rwen_o <= rwen_i;
          if (ren_i || wen_i) begin
            state     <= S_BUSY;
            mem_req_o <= 1'b1;
          end else begin
            state   <= S_WAIT;
            valid_o <= 1'b1;
          end
        end
        S_BUSY: if (mem_done) begin
          state     <= S_WAIT;
          mem_req_o <= 1'b0;
          valid_o   <= 1'b1;
        end
        S_WAIT: if (next_ready_i) begin
          state   <= S_IDLE;
          valid_o <= 1'b0;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opcode_q <= opcode_i;
      alu_op_q <= alu_op_i;
      imm_q    <= imm_i;
      pc_q     <= pc_i;
      src1_q   <= op1_i;
      src2_q   <= op2_i;
      addr_q   <= op_j_i + imm_i; // Jump/branch target and memory address.
      rd_o     <= rd_i;
      ren_q    <= ren_i;
      wen_q    <= wen_i;
    end
    if (state == S_BUSY && mem_rvalid_i) mem_rdata_q <= mem_rdata_i;
  end

  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = src2_q;
  assign mem_we_o    = wen_q;

  exu_alu u_alu (.a_i(src1_q), .b_i(src2_q), .op_i(alu_op_q), .res_o(alu_res));

  assign is_sys    = (opcode_q == exu_pkg::OP_SYSTEM);
  assign is_priv   = is_sys && (imm_q[3:0] == exu_pkg::F3_PRIV);
  assign is_ecall  = is_priv && (imm_q[15:4] == exu_pkg::FN_ECALL);
  assign is_mret   = is_priv && (imm_q[15:4] == exu_pkg::FN_MRET);
  assign is_ebreak = is_priv && (imm_q[15:4] == exu_pkg::FN_EBREAK);

  assign csr_addr = is_ecall ? exu_pkg::CSR_MCAUSE :
                    is_mret  ? exu_pkg::CSR_MSTATUS : imm_q[15:4];

  always_comb begin
    csr_wen   = 1'b0;
    csr_wdata = '0;
    if (is_ecall) begin
      csr_wen   = 1'b1;
      csr_wdata = exu_pkg::ECALL_CAUSE;
    end else if (is_mret) begin
      csr_wen   = 1'b1; // MPIE back into MIE, MPIE set.
      csr_wdata = {csr_rdata[63:8], 1'b1, csr_rdata[6:4], csr_rdata[7], csr_rdata[2:0]};
    end else if (is_sys) begin
      case (imm_q[3:0])
        exu_pkg::F3_CSRRW, exu_pkg::F3_CSRRWI: begin
          csr_wen   = 1'b1;
          csr_wdata = src1_q;
        end
        exu_pkg::F3_CSRRS, exu_pkg::F3_CSRRSI: begin
          csr_wen   = 1'b1;
          csr_wdata = csr_rdata | src1_q;
        end
        exu_pkg::F3_CSRRC, exu_pkg::F3_CSRRCI: begin
          csr_wen   = 1'b1;
          csr_wdata = csr_rdata & ~src1_q;
        end
        default: ;
      endcase
    end
  end

  exu_csr_file u_csr (
    .clk(clk), .rst(rst),
    .we_i(csr_wen && commit), .ecall_i(is_ecall && commit),
    .waddr_i(csr_addr), .waddr2_i(exu_pkg::CSR_MEPC),
    .wdata_i(csr_wdata), .wdata2_i(pc_q),
    .rdata_o(csr_rdata), .mepc_o(mepc), .mtvec_o(mtvec)
  );

  assign reg_wdata_o = (opcode_q == exu_pkg::OP_LOAD) ? mem_rdata_q :
                       is_sys ? csr_rdata : alu_res;

  always_comb begin
    use_npc_o   = 1'b0;
    ebreak_o    = 1'b0;
    npc_wdata_o = addr_q;
    case (opcode_q)
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: use_npc_o = 1'b1;
      exu_pkg::OP_BRANCH: begin
        // SUB compares for equality, the rest return a set flag.
        use_npc_o = (alu_op_q == exu_pkg::ALU_SUB) ? ~|alu_res : |alu_res;
      end
      exu_pkg::OP_SYSTEM: begin
        if (is_ecall) begin
          use_npc_o   = 1'b1;
          npc_wdata_o = mtvec;
        end else if (is_mret) begin
          use_npc_o   = 1'b1;
          npc_wdata_o = mepc;
        end else if (is_ebreak) begin
          use_npc_o = 1'b1;
          ebreak_o  = 1'b1;
        end
      end
      default: ;
    endcase
  end

  a_no_valid_during_req: assert property (@(posedge clk) disable iff (rst)
    !(valid_o && mem_req_o));
  a_busy_while_valid: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> !ready_o);

endmodule

// File: exu_top.sv
`timescale 1ns/10ps

module exu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     prev_valid_i,
  input  logic                     next_ready_i,
  output logic                     ready_o,
  output logic                     valid_o,
  input  logic                     ren_i,
  input  logic                     wen_i,
  input  logic                     rwen_i,
  input  logic [4:0]               rd_i,
  input  logic [exu_pkg::XLEN-1:0] imm_i,
  input  logic [exu_pkg::XLEN-1:0] op1_i,
  input  logic [exu_pkg::XLEN-1:0] op2_i,
  input  logic [exu_pkg::XLEN-1:0] op_j_i,
  input  logic [3:0]               alu_op_i,
  input  logic [6:0]               opcode_i,
  input  logic [exu_pkg::XLEN-1:0] pc_i,
  output logic [exu_pkg::XLEN-1:0] reg_wdata_o,
  output logic [exu_pkg::XLEN-1:0] npc_wdata_o,
  output logic                     use_npc_o,
  output logic                     ebreak_o,
  output logic [4:0]               rd_o,
  output logic                     rwen_o
);

  logic                     mem_req, mem_we, mem_rvalid, mem_wready;
  logic [exu_pkg::XLEN-1:0] mem_addr, mem_wdata, mem_rdata;

  exu_stage u_stage (
    .clk(clk), .rst(rst),
    .prev_valid_i(prev_valid_i), .next_ready_i(next_ready_i),
    .ready_o(ready_o), .valid_o(valid_o),
    .ren_i(ren_i), .wen_i(wen_i), .rwen_i(rwen_i), .rd_i(rd_i),
    .imm_i(imm_i), .op1_i(op1_i), .op2_i(op2_i), .op_j_i(op_j_i),
    .alu_op_i(alu_op_i), .opcode_i(opcode_i), .pc_i(pc_i),
    .reg_wdata_o(reg_wdata_o), .npc_wdata_o(npc_wdata_o),
    .use_npc_o(use_npc_o), .ebreak_o(ebreak_o),
    .rd_o(rd_o), .rwen_o(rwen_o),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_we_o(mem_we),
    .mem_rdata_i(mem_rdata), .mem_rvalid_i(mem_rvalid), .mem_wready_i(mem_wready)
  );

  exu_data_mem u_mem (
    .clk(clk), .rst(rst),
    .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
    .rdata_o(mem_rdata), .rvalid_o(mem_rvalid), .wready_o(mem_wready)
  );

endmodule

// File: tb_exu_top.sv
`timescale 1ns/10ps

module tb_exu_top;

  localparam int MAX_CASES = 64;
  localparam int NFIELDS   = 13;
  // Column order of exu_cases.txt.
  localparam int F_OPCODE  = 0;
  localparam int F_ALUOP   = 1;
  localparam int F_IMM     = 2;
  localparam int F_OP1     = 3;
  localparam int F_OP2     = 4;
  localparam int F_OPJ     = 5;
  localparam int F_PC      = 6;
  localparam int F_REN     = 7;
  localparam int F_WEN     = 8;
  localparam int F_WDATA   = 9;
  localparam int F_USENPC  = 10;
  localparam int F_NPC     = 11;
  localparam int F_STALL   = 12;
  localparam logic [15:0] LFSR_SEED = 16'd43077;
  localparam logic [15:0] LFSR_TAPS = 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1.

  logic        clk = 1'b0;
  logic        rst;
  logic        prev_valid_i;
  logic        next_ready_i;
  logic        ready_o;
  logic        valid_o;
  logic        ren_i;
  logic        wen_i;
  logic        rwen_i;
  logic [4:0]  rd_i;
  logic [63:0] imm_i;
  logic [63:0] op1_i;
  logic [63:0] op2_i;
  logic [63:0] op_j_i;
  logic [3:0]  alu_op_i;
  logic [6:0]  opcode_i;
  logic [63:0] pc_i;
  logic [63:0] reg_wdata_o;
  logic [63:0] npc_wdata_o;
  logic        use_npc_o;
  logic        ebreak_o;
  logic [4:0]  rd_o;
  logic        rwen_o;

  logic [63:0] case_tab [0:MAX_CASES-1][0:NFIELDS-1];
  int          num_cases = 0;
  int          cur_case = 0;
  int          errors = 0;
  int          checks = 0;
  logic        loaded = 1'b0;
  logic [15:0] lfsr = LFSR_SEED;

  exu_top UUT (
    .clk(clk), .rst(rst),
    .prev_valid_i(prev_valid_i), .next_ready_i(next_ready_i),
    .ready_o(ready_o), .valid_o(valid_o),
    .ren_i(ren_i), .wen_i(wen_i), .rwen_i(rwen_i), .rd_i(rd_i),
    .imm_i(imm_i), .op1_i(op1_i), .op2_i(op2_i), .op_j_i(op_j_i),
    .alu_op_i(alu_op_i), .opcode_i(opcode_i), .pc_i(pc_i),
    .reg_wdata_o(reg_wdata_o), .npc_wdata_o(npc_wdata_o),
    .use_npc_o(use_npc_o), .ebreak_o(ebreak_o), .rd_o(rd_o), .rwen_o(rwen_o)
  );

  always #50 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = (s >> 1) ^ (s[0] ? LFSR_TAPS : 16'h0000);
  endfunction

  // One LFSR step per bit taken.
  task automatic draw_bits(input int n, output logic [3:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val  = {val[2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: case %0d %s got %h expected %h", $time, cur_case, what, got, exp);
    end
  endtask

  task automatic load_cases(output logic ok);
    int          fd;
    int          code;
    string       line;
    logic [63:0] f [0:NFIELDS-1];
    int          j;
    ok = 1'b0;
    fd = $fopen("exu_cases.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != 8'h23 && num_cases < MAX_CASES) begin // Skip comments.
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                         f[7], f[8], f[9], f[10], f[11], f[12]);
          if (code == NFIELDS) begin
            for (j = 0; j < NFIELDS; j++) case_tab[num_cases][j] = f[j];
            num_cases++;
          end
        end
      end
      $fclose(fd);
      ok = (num_cases > 0);
    end
  endtask

  task automatic run_case(input int idx);
    logic [63:0] exp_wdata;
    logic [63:0] exp_npc;
    logic [63:0] got_wdata;
    logic [63:0] got_npc;
    logic        got_use_npc;
    logic        exp_use_npc;
    logic        exp_ebreak;
    logic        is_mem;
    logic [3:0]  stall;
    int          lat;
    int          k;
    cur_case    = idx;
    exp_wdata   = case_tab[idx][F_WDATA];
    exp_npc     = case_tab[idx][F_NPC];
    exp_use_npc = case_tab[idx][F_USENPC][0];
    is_mem      = case_tab[idx][F_REN][0] | case_tab[idx][F_WEN][0];
    exp_ebreak  = (case_tab[idx][F_OPCODE][6:0] == exu_pkg::OP_SYSTEM) &&
                  (case_tab[idx][F_IMM][15:0] == {exu_pkg::FN_EBREAK, exu_pkg::F3_PRIV});
    stall = case_tab[idx][F_STALL][3:0];
    if (stall == 4'hf) draw_bits(2, stall); // Random stall of 0 to 3 cycles.
    check_value(64'(ready_o), 64'd1, "ready_o when idle");
    @(posedge clk);
    opcode_i     <= case_tab[idx][F_OPCODE][6:0];
    alu_op_i     <= case_tab[idx][F_ALUOP][3:0];
    imm_i        <= case_tab[idx][F_IMM];
    op1_i        <= case_tab[idx][F_OP1];
    op2_i        <= case_tab[idx][F_OP2];
    op_j_i       <= case_tab[idx][F_OPJ];
    pc_i         <= case_tab[idx][F_PC];
    ren_i        <= case_tab[idx][F_REN][0];
    wen_i        <= case_tab[idx][F_WEN][0];
    rd_i         <= 5'(idx);
    rwen_i       <= idx[0];
    prev_valid_i <= 1'b1;
    next_ready_i <= (stall == 4'h0);
    @(posedge clk); // Accepting edge.
    prev_valid_i <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!valid_o);
    // Memory ops add the request cycle, MEM_LAT in the memory, then the response.
    check_value(64'(lat), 64'(is_mem ? exu_pkg::MEM_LAT + 2 : 1), "valid_o latency");
    got_wdata   = reg_wdata_o;
    got_npc     = npc_wdata_o;
    got_use_npc = use_npc_o;
    check_value(reg_wdata_o, exp_wdata, "reg_wdata_o");
    check_value(64'(use_npc_o), 64'(exp_use_npc), "use_npc_o");
    if (exp_use_npc && !exp_ebreak) check_value(npc_wdata_o, exp_npc, "npc_wdata_o");
    check_value(64'(ebreak_o), 64'(exp_ebreak), "ebreak_o");
    check_value(64'(rd_o), 64'(idx[4:0]), "rd_o");
    check_value(64'(rwen_o), 64'(idx[0]), "rwen_o");
    check_value(64'(ready_o), 64'd0, "ready_o while valid");
    for (k = 0; k < int'(stall); k++) begin
      @(posedge clk);
      if (k == int'(stall) - 1) next_ready_i <= 1'b1;
      @(negedge clk);
      check_value(64'(valid_o), 64'd1, "valid_o during stall");
      check_value(64'(ready_o), 64'd0, "ready_o during stall");
      check_value(reg_wdata_o, got_wdata, "reg_wdata_o held");
      check_value(npc_wdata_o, got_npc, "npc_wdata_o held");
      check_value(64'(use_npc_o), 64'(got_use_npc), "use_npc_o held");
    end
    @(posedge clk); // Completion edge.
    next_ready_i <= 1'b0;
    @(negedge clk);
    check_value(64'(valid_o), 64'd0, "valid_o after completion");
    check_value(64'(ready_o), 64'd1, "ready_o after completion");
  endtask

  initial begin : main_seq
    logic file_ok;
    int   i;
    rst          = 1'b1;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    ren_i        = 1'b0;
    wen_i        = 1'b0;
    rwen_i       = 1'b0;
    rd_i         = '0;
    imm_i        = '0;
    op1_i        = '0;
    op2_i        = '0;
    op_j_i       = '0;
    alu_op_i     = '0;
    opcode_i     = '0;
    pc_i         = '0;
    load_cases(file_ok);
    loaded = 1'b1;
    if (!file_ok) begin
      $display("Could not read any case from exu_cases.txt");
      $display("Result: FAILED");
      $finish;
    end else begin
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      for (i = 0; i < num_cases; i++) run_case(i);
      $display("Summary: %0d cases, %0d checks, %0d errors", num_cases, checks, errors);
      if (errors == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

  // Bounds the run by the number of cases.
  initial begin : watchdog
    wait (loaded);
    repeat (num_cases * 20 + 50) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding",
             num_cases * 20 + 50);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: exu_cases.txt
# opcode alu_op imm op1 op2 op_j pc ren wen exp_reg_wdata exp_use_npc exp_npc stall
# All columns hex. A stall of f draws 0 to 3 cycles from the LFSR.
33 0 0 7fffffffffffffff 1 0 0 0 0 8000000000000000 0 0 0
33 1 0 0 1 0 0 0 0 ffffffffffffffff 0 0 f
33 4 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 0 0 f0f0f0f0f0f0f0f0 0 0 2
33 7 0 8000000000000000 4 0 0 0 0 f800000000000000 0 0 f
33 7 0 8000000000000001 3f 0 0 0 0 ffffffffffffffff 0 0 1
33 8 0 ffffffffffffffff 1 0 0 0 0 1 0 0 f
33 9 0 ffffffffffffffff 1 0 0 0 0 0 0 0 0
33 9 0 1 ffffffffffffffff 0 0 0 0 1 0 0 3
33 5 0 1 3f 0 0 0 0 8000000000000000 0 0 f
33 6 0 8000000000000000 3f 0 0 0 0 1 0 0 0
13 0 0 10 fffffffffffffff0 0 0 0 0 0 0 0 f
63 1 20 5 5 1000 1000 0 0 0 1 1020 f
63 1 20 5 6 1000 1000 0 0 ffffffffffffffff 0 0 1
63 8 fffffffffffffff8 ffffffffffffff00 1 2000 2000 0 0 1 1 1ff8 f
63 9 fffffffffffffff8 ffffffffffffff00 1 2000 2000 0 0 0 0 0 0
63 a 4 7 7 3000 3000 0 0 1 1 3004 2
6f 0 100 4000 4 4000 4000 0 0 4004 1 4100 f
67 0 8 6000 4 5000 6000 0 0 6004 1 5008 0
73 0 3051 80000000 0 0 0 0 0 0 0 0 f
73 0 3052 f0 0 0 0 0 0 80000000 0 0 1
73 0 3053 80000030 0 0 0 0 0 800000f0 0 0 f
73 0 3052 0 0 0 0 0 0 c0 0 0 0
73 0 0 0 0 0 7000 0 0 0 1 c0 f
73 0 3412 0 0 0 0 0 0 7000 0 0 0
73 0 3422 0 0 0 0 0 0 b 0 0 f
73 0 3006 80 0 0 0 0 0 0 0 0 2
73 0 3020 0 0 0 8000 0 0 80 1 7000 f
73 0 3007 8 0 0 0 0 0 88 0 0 1
73 0 3002 0 0 0 0 0 0 80 0 0 f
73 0 10 0 0 0 9000 0 0 0 1 0 0
23 0 8 0 0123456789abcdef 100 0 0 1 0123456789abcdef 0 0 f
03 0 8 0 0 100 0 1 0 0123456789abcdef 0 0 1
23 0 ff8 0 fedcba9876543210 800 0 0 1 fedcba9876543210 0 0 f
03 0 7f8 0 0 1000 0 1 0 fedcba9876543210 0 0 0
03 0 0 0 0 200 0 1 0 0 0 0 f
03 0 10 0 0 0 0 1 0 0 0 0 2

// File: src.f
exu_pkg.sv
exu_alu.sv
exu_csr_file.sv
exu_data_mem.sv
exu_stage.sv
exu_top.sv
tb_exu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_exu_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_exu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi
exit 0
